/* src/afu_consts.svh */
/*
 * Accelerator shell constants
 * Widths, local memory depth, CSR offsets and the AFU identifier
 */
`ifndef AFU_CONSTS_SVH
`define AFU_CONSTS_SVH

`define ASP_DATA_W              32
`define ASP_HOST_ADDR_W         16
`define ASP_LMEM_DEPTH          256
`define ASP_LMEM_ADDR_W         8
// Wide enough to hold a full-bank length of 256
`define ASP_LEN_W               9
`define ASP_MMIO_ADDR_W         4
`define ASP_AFU_ID              32'hA5F0_0C11
`define ASP_DMA_MAX_OUTSTANDING 4

// CSR register indexes
`define ASP_CSR_ID              4'h0
`define ASP_CSR_STATUS          4'h1
`define ASP_CSR_DMA_SRC         4'h2
`define ASP_CSR_DMA_DST         4'h3
`define ASP_CSR_DMA_LEN         4'h4
`define ASP_CSR_KERN_BASE       4'h5
`define ASP_CSR_KERN_LEN        4'h6
`define ASP_CSR_KERN_RESULT     4'h7
`define ASP_CSR_CONTROL         4'h8

`endif

/* src/asp_mem_pkg.sv */
/*
 * Memory-side types: host read requests and responses,
 * local memory requests and read data
 */
`default_nettype none
`include "afu_consts.svh"

package asp_mem_pkg;

    // Word address into host memory
    typedef struct packed {
        logic [`ASP_HOST_ADDR_W-1:0] addr;
    } host_req_t;

    typedef struct packed {
        logic [`ASP_DATA_W-1:0] data;
    } host_rsp_t;

    // Write when wr is set, read otherwise
    typedef struct packed {
        logic                        wr;
        logic [`ASP_LMEM_ADDR_W-1:0] addr;
        logic [`ASP_DATA_W-1:0]      wdata;
    } lmem_req_t;

    typedef struct packed {
        logic [`ASP_DATA_W-1:0] rdata;
    } lmem_rsp_t;

endpackage : asp_mem_pkg

`default_nettype wire

/* src/asp_ctrl_pkg.sv */
/*
 * Control-side types: MMIO operations and register indexes,
 * MMIO request and response, DMA and kernel commands
 */
`default_nettype none
`include "afu_consts.svh"

package asp_ctrl_pkg;

    typedef enum logic {
        MMIO_RD = 1'b0,
        MMIO_WR = 1'b1
    } mmio_op_e;

    typedef enum logic [`ASP_MMIO_ADDR_W-1:0] {
        CSR_ID          = `ASP_CSR_ID,
        CSR_STATUS      = `ASP_CSR_STATUS,
        CSR_DMA_SRC     = `ASP_CSR_DMA_SRC,
        CSR_DMA_DST     = `ASP_CSR_DMA_DST,
        CSR_DMA_LEN     = `ASP_CSR_DMA_LEN,
        CSR_KERN_BASE   = `ASP_CSR_KERN_BASE,
        CSR_KERN_LEN    = `ASP_CSR_KERN_LEN,
        CSR_KERN_RESULT = `ASP_CSR_KERN_RESULT,
        CSR_CONTROL     = `ASP_CSR_CONTROL
    } csr_idx_e;

    typedef struct packed {
        mmio_op_e               op;
        csr_idx_e               idx;
        logic [`ASP_DATA_W-1:0] wdata;
    } mmio_req_t;

    typedef struct packed {
        logic [`ASP_DATA_W-1:0] rdata;
    } mmio_rsp_t;

    // Host source, local destination, length in words
    typedef struct packed {
        logic [`ASP_HOST_ADDR_W-1:0] src;
        logic [`ASP_LMEM_ADDR_W-1:0] dst;
        logic [`ASP_LEN_W-1:0]       len;
    } dma_cmd_t;

    typedef struct packed {
        logic [`ASP_LMEM_ADDR_W-1:0] base;
        logic [`ASP_LEN_W-1:0]       len;
    } kern_cmd_t;

endpackage : asp_ctrl_pkg

`default_nettype wire

/* src/mmio_csr.sv */
/*
 * MMIO register block: decodes host reads and writes,
 * holds DMA and kernel commands and issues their start pulses
 */
`default_nettype none
`include "afu_consts.svh"

module mmio_csr
import asp_ctrl_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   mmio_req_valid,
    input  mmio_req_t              mmio_req,
    output logic                   mmio_req_ready,
    output logic                   mmio_rsp_valid,
    output mmio_rsp_t              mmio_rsp,

    output dma_cmd_t               dma_cmd,
    output logic                   dma_start,
    input  logic                   dma_busy,
    input  logic                   dma_done,

    output kern_cmd_t              kern_cmd,
    output logic                   kern_start,
    input  logic                   kern_busy,
    input  logic                   kern_done,
    input  logic [`ASP_DATA_W-1:0] kern_result
);

logic                   rd_go, wr_go, wr_ctrl;
logic                   dma_done_q, kern_done_q;
logic [`ASP_DATA_W-1:0] rd_data;

// Hold off new requests while a read response is on the bus
assign mmio_req_ready = !mmio_rsp_valid;
assign rd_go   = mmio_req_valid && mmio_req_ready && (mmio_req.op == MMIO_RD);
assign wr_go   = mmio_req_valid && mmio_req_ready && (mmio_req.op == MMIO_WR);
assign wr_ctrl = wr_go && (mmio_req.idx == CSR_CONTROL);

// Starts to a busy engine are dropped
assign dma_start  = wr_ctrl && mmio_req.wdata[0] && !dma_busy;
assign kern_start = wr_ctrl && mmio_req.wdata[1] && !kern_busy;

always_comb begin
    case (mmio_req.idx)
        CSR_ID:          rd_data = `ASP_AFU_ID;
        CSR_STATUS:      rd_data = `ASP_DATA_W'({kern_done_q, kern_busy, dma_done_q, dma_busy});
        CSR_DMA_SRC:     rd_data = `ASP_DATA_W'(dma_cmd.src);
        CSR_DMA_DST:     rd_data = `ASP_DATA_W'(dma_cmd.dst);
        CSR_DMA_LEN:     rd_data = `ASP_DATA_W'(dma_cmd.len);
        CSR_KERN_BASE:   rd_data = `ASP_DATA_W'(kern_cmd.base);
        CSR_KERN_LEN:    rd_data = `ASP_DATA_W'(kern_cmd.len);
        CSR_KERN_RESULT: rd_data = kern_result;
        default:         rd_data = '0;
    endcase
end

always_ff @(posedge clk) begin
    if (rst) begin
        dma_cmd        <= '0;
        kern_cmd       <= '0;
        dma_done_q     <= 1'b0;
        kern_done_q    <= 1'b0;
        mmio_rsp_valid <= 1'b0;
    end else begin
        mmio_rsp_valid <= rd_go;
        if (wr_go) begin
            case (mmio_req.idx)
                CSR_DMA_SRC:   dma_cmd.src   <= mmio_req.wdata[`ASP_HOST_ADDR_W-1:0];
                CSR_DMA_DST:   dma_cmd.dst   <= mmio_req.wdata[`ASP_LMEM_ADDR_W-1:0];
                CSR_DMA_LEN:   dma_cmd.len   <= mmio_req.wdata[`ASP_LEN_W-1:0];
                CSR_KERN_BASE: kern_cmd.base <= mmio_req.wdata[`ASP_LMEM_ADDR_W-1:0];
                CSR_KERN_LEN:  kern_cmd.len  <= mmio_req.wdata[`ASP_LEN_W-1:0];
                default: ;
            endcase
        end
        // Sticky done, cleared by the next start
        if (dma_done) begin
            dma_done_q <= 1'b1;
        end
        if (dma_start) begin
            dma_done_q <= 1'b0;
        end
        if (kern_done) begin
            kern_done_q <= 1'b1;
        end
        if (kern_start) begin
            kern_done_q <= 1'b0;
        end
    end
end

always_ff @(posedge clk) begin
    if (rd_go) begin
        mmio_rsp.rdata <= rd_data;
    end
end

// A started engine goes busy on the next cycle
a_dma_start_idle: assert property (@(posedge clk) disable iff (rst)
    dma_start |=> dma_busy);
a_kern_start_idle: assert property (@(posedge clk) disable iff (rst)
    kern_start |=> kern_busy);

endmodule : mmio_csr

`default_nettype wire

/* src/dma_engine.sv */
/*
 * Host-to-local DMA engine with several host reads in flight
 * and a small response FIFO in front of local memory
 */
`default_nettype none
`include "afu_consts.svh"

module dma_engine
import asp_mem_pkg::*, asp_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  dma_cmd_t  dma_cmd,
    input  logic      dma_start,
    output logic      dma_busy,
    output logic      dma_done,

    output logic      host_req_valid,
    output host_req_t host_req,
    input  logic      host_req_ready,
    input  logic      host_rsp_valid,
    input  host_rsp_t host_rsp,

    output logic      dma_lmem_valid,
    output lmem_req_t dma_lmem_req,
    input  logic      dma_lmem_ready
);

localparam int MAX_OUT = `ASP_DMA_MAX_OUTSTANDING;
localparam int CNT_W   = $clog2(MAX_OUT + 1);
localparam int PTR_W   = $clog2(MAX_OUT);

typedef enum logic [1:0] {IDLE, RUN, DRAIN} dma_state_e;

dma_state_e                  state;
logic [`ASP_HOST_ADDR_W-1:0] req_addr;
logic [`ASP_LMEM_ADDR_W-1:0] wr_addr;
logic [`ASP_LEN_W-1:0]       issue_left, wr_left;
logic [CNT_W-1:0]            inflight, fifo_cnt;
logic [CNT_W:0]              credit_used;
logic [PTR_W-1:0]            wr_ptr, rd_ptr;
logic [`ASP_DATA_W-1:0]      fifo_q [MAX_OUT];
logic                        req_go, pop;

// Every read in flight has a FIFO slot reserved for its response
assign credit_used    = inflight + fifo_cnt;
assign host_req_valid = (state == RUN) && (issue_left != '0) && (int'(credit_used) < MAX_OUT);
assign host_req.addr  = req_addr;
assign req_go         = host_req_valid && host_req_ready;

assign dma_lmem_valid = (fifo_cnt != '0);
assign pop            = dma_lmem_valid && dma_lmem_ready;

always_comb begin
    dma_lmem_req.wr    = 1'b1;
    dma_lmem_req.addr  = wr_addr;
    dma_lmem_req.wdata = fifo_q[rd_ptr];
end

assign dma_busy = (state != IDLE);
assign dma_done = (state == DRAIN) && (wr_left == '0);

always_ff @(posedge clk) begin
    if (rst) begin
        state      <= IDLE;
        req_addr   <= '0;
        wr_addr    <= '0;
        issue_left <= '0;
        wr_left    <= '0;
        inflight   <= '0;
        fifo_cnt   <= '0;
        wr_ptr     <= '0;
        rd_ptr     <= '0;
    end else begin
        inflight <= inflight + CNT_W'(req_go) - CNT_W'(host_rsp_valid);
        fifo_cnt <= fifo_cnt + CNT_W'(host_rsp_valid) - CNT_W'(pop);
        if (host_rsp_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (req_go) begin
            req_addr   <= req_addr + 1'b1;
            issue_left <= issue_left - 1'b1;
        end
        if (pop) begin
            rd_ptr  <= rd_ptr + 1'b1;
            wr_addr <= wr_addr + 1'b1;
            wr_left <= wr_left - 1'b1;
        end
        case (state)
            IDLE: begin
                if (dma_start) begin
                    state      <= RUN;
                    req_addr   <= dma_cmd.src;
                    issue_left <= dma_cmd.len;
                    wr_addr    <= dma_cmd.dst;
                    wr_left    <= dma_cmd.len;
                end
            end
            RUN: begin
                if (issue_left == '0) begin
                    state <= DRAIN;
                end
            end
            DRAIN: begin
                if (wr_left == '0) begin
                    state <= IDLE;
                end
            end
            default: state <= IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (host_rsp_valid) begin
        fifo_q[wr_ptr] <= host_rsp.data;
    end
end

a_inflight_max: assert property (@(posedge clk) disable iff (rst)
    int'(inflight) <= MAX_OUT);
// Host memory only answers reads this engine issued
a_rsp_expected: assert property (@(posedge clk) disable iff (rst)
    host_rsp_valid |-> inflight != '0);

endmodule : dma_engine

`default_nettype wire

/* src/local_mem_bank.sv */
/*
 * Single-port local RAM shared by the DMA and the kernel,
 * buffered DMA writes take the port ahead of kernel reads
 */
`default_nettype none
`include "afu_consts.svh"

module local_mem_bank
import asp_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      dma_lmem_valid,
    input  lmem_req_t dma_lmem_req,
    output logic      dma_lmem_ready,

    input  logic      kern_lmem_valid,
    input  lmem_req_t kern_lmem_req,
    output logic      kern_lmem_ready,

    output logic      lmem_rsp_valid,
    output lmem_rsp_t lmem_rsp
);

logic [`ASP_DATA_W-1:0] mem [`ASP_LMEM_DEPTH];
lmem_req_t              wbuf, port_req;
logic                   wbuf_valid, port_go, wr_go, rd_go;

// Each accepted DMA write is parked for one cycle,
// then takes the port ahead of the kernel
assign dma_lmem_ready  = !wbuf_valid;
assign kern_lmem_ready = !wbuf_valid;

assign port_req = wbuf_valid ? wbuf : kern_lmem_req;
assign port_go  = wbuf_valid || kern_lmem_valid;
assign wr_go    = port_go && port_req.wr;
assign rd_go    = port_go && !port_req.wr;

always_ff @(posedge clk) begin
    if (rst) begin
        wbuf_valid     <= 1'b0;
        lmem_rsp_valid <= 1'b0;
    end else begin
        wbuf_valid     <= dma_lmem_valid && dma_lmem_ready;
        lmem_rsp_valid <= rd_go;
    end
end

always_ff @(posedge clk) begin
    if (dma_lmem_valid && dma_lmem_ready) begin
        wbuf <= dma_lmem_req;
    end
end

always_ff @(posedge clk) begin
    if (wr_go) begin
        mem[port_req.addr] <= port_req.wdata;
    end
    if (rd_go) begin
        lmem_rsp.rdata <= mem[port_req.addr];
    end
end

// An accepted DMA write owns the port as a write on the next cycle
a_dma_first: assert property (@(posedge clk) disable iff (rst)
    (dma_lmem_valid && dma_lmem_ready) |=>
        (wr_go && (port_req.addr == $past(dma_lmem_req.addr))));

endmodule : local_mem_bank

`default_nettype wire

/* src/kernel_accum.sv */
/*
 * Sum kernel: streams a local memory range and
 * accumulates a wrapping 32-bit sum
 */
`default_nettype none
`include "afu_consts.svh"

module kernel_accum
import asp_mem_pkg::*, asp_ctrl_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    input  kern_cmd_t              kern_cmd,
    input  logic                   kern_start,
    output logic                   kern_busy,
    output logic                   kern_done,
    output logic [`ASP_DATA_W-1:0] kern_result,

    output logic                   kern_lmem_valid,
    output lmem_req_t              kern_lmem_req,
    input  logic                   kern_lmem_ready,
    input  logic                   lmem_rsp_valid,
    input  lmem_rsp_t              lmem_rsp
);

typedef enum logic [1:0] {IDLE, READ, WAIT} kern_state_e;

kern_state_e                 state;
logic [`ASP_LMEM_ADDR_W-1:0] issue_addr;
logic [`ASP_LEN_W-1:0]       issue_left, ret_left;
logic                        rd_go;

assign kern_lmem_valid = (state == READ) && (issue_left != '0);
assign rd_go           = kern_lmem_valid && kern_lmem_ready;

always_comb begin
    kern_lmem_req.wr    = 1'b0;
    kern_lmem_req.addr  = issue_addr;
    kern_lmem_req.wdata = '0;
end

assign kern_busy = (state != IDLE);
assign kern_done = (state == WAIT) && (ret_left == '0);

always_ff @(posedge clk) begin
    if (rst) begin
        state       <= IDLE;
        issue_addr  <= '0;
        issue_left  <= '0;
        ret_left    <= '0;
        kern_result <= '0;
    end else begin
        case (state)
            IDLE: begin
                if (kern_start) begin
                    state       <= READ;
                    issue_addr  <= kern_cmd.base;
                    issue_left  <= kern_cmd.len;
                    ret_left    <= kern_cmd.len;
                    kern_result <= '0;
                end
            end
            READ: begin
                if (rd_go) begin
                    issue_addr <= issue_addr + 1'b1;
                    issue_left <= issue_left - 1'b1;
                end
                if (issue_left == '0) begin
                    state <= WAIT;
                end
            end
            WAIT: begin
                if (ret_left == '0) begin
                    state <= IDLE;
                end
            end
            default: state <= IDLE;
        endcase
        // Returns overlap with issue, counted on their own
        if (lmem_rsp_valid) begin
            kern_result <= kern_result + lmem_rsp.rdata;
            ret_left    <= ret_left - 1'b1;
        end
    end
end

endmodule : kernel_accum

`default_nettype wire

/* src/afu.sv */
/*
 * Accelerator top level: MMIO registers, host DMA,
 * local memory bank and sum kernel on one clock
 */
`default_nettype none
`include "afu_consts.svh"

module afu
import asp_mem_pkg::*, asp_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // Host MMIO
    input  logic      mmio_req_valid,
    input  mmio_req_t mmio_req,
    output logic      mmio_req_ready,
    output logic      mmio_rsp_valid,
    output mmio_rsp_t mmio_rsp,

    // Host memory reads
    output logic      host_req_valid,
    output host_req_t host_req,
    input  logic      host_req_ready,
    input  logic      host_rsp_valid,
    input  host_rsp_t host_rsp
);

dma_cmd_t               dma_cmd;
logic                   dma_start, dma_busy, dma_done;
kern_cmd_t              kern_cmd;
logic                   kern_start, kern_busy, kern_done;
logic [`ASP_DATA_W-1:0] kern_result;

lmem_req_t              dma_lmem_req, kern_lmem_req;
logic                   dma_lmem_valid, dma_lmem_ready;
logic                   kern_lmem_valid, kern_lmem_ready;
logic                   lmem_rsp_valid;
lmem_rsp_t              lmem_rsp;

mmio_csr mmio_csr_inst (
    .clk, .rst,
    .mmio_req_valid, .mmio_req, .mmio_req_ready, .mmio_rsp_valid, .mmio_rsp,
    .dma_cmd, .dma_start, .dma_busy, .dma_done,
    .kern_cmd, .kern_start, .kern_busy, .kern_done, .kern_result
);

dma_engine dma_engine_inst (
    .clk, .rst,
    .dma_cmd, .dma_start, .dma_busy, .dma_done,
    .host_req_valid, .host_req, .host_req_ready, .host_rsp_valid, .host_rsp,
    .dma_lmem_valid, .dma_lmem_req, .dma_lmem_ready
);

local_mem_bank local_mem_bank_inst (
    .clk, .rst,
    .dma_lmem_valid, .dma_lmem_req, .dma_lmem_ready,
    .kern_lmem_valid, .kern_lmem_req, .kern_lmem_ready,
    .lmem_rsp_valid, .lmem_rsp
);

kernel_accum kernel_accum_inst (
    .clk, .rst,
    .kern_cmd, .kern_start, .kern_busy, .kern_done, .kern_result,
    .kern_lmem_valid, .kern_lmem_req, .kern_lmem_ready,
    .lmem_rsp_valid, .lmem_rsp
);

endmodule : afu

`default_nettype wire

/* bench/host_mem_model.sv */
/*
 * Host memory model: random-filled word memory that accepts reads with
 * random back-pressure and answers them in order after 1 to 6 cycles
 */
`default_nettype none
`include "afu_consts.svh"

module host_mem_model
import asp_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      host_req_valid,
    input  host_req_t host_req,
    output logic      host_req_ready,
    output logic      host_rsp_valid,
    output host_rsp_t host_rsp,
    output int        req_count,
    output int        err_count
);

logic [`ASP_DATA_W-1:0]      mem [1 << `ASP_HOST_ADDR_W];
logic [`ASP_HOST_ADDR_W-1:0] next_addr;
int                          cyc, due, last_due;
int                          due_q [$];
logic [`ASP_DATA_W-1:0]      data_q [$];

// Sets the address that the next accepted read must carry
task automatic expect_reads(input logic [`ASP_HOST_ADDR_W-1:0] base);
    next_addr = base;
endtask

initial begin
    host_req_ready = 1'b0;
    host_rsp_valid = 1'b0;
    host_rsp       = '0;
    req_count      = 0;
    err_count      = 0;
    next_addr      = '0;
    void'($urandom(32'h8cf4));
    for (int a = 0; a < (1 << `ASP_HOST_ADDR_W); a++) begin
        mem[a] = $urandom();
    end
end

// Everything moves on the falling edge, the DUT samples on the rising one
always @(negedge clk) begin
    if (rst) begin
        host_req_ready = 1'b0;
        host_rsp_valid = 1'b0;
        cyc            = 0;
        last_due       = 0;
        due_q.delete();
        data_q.delete();
    end else begin
        cyc++;
        if (due_q.size() != 0 && due_q[0] <= cyc) begin
            void'(due_q.pop_front());
            host_rsp_valid = 1'b1;
            host_rsp.data  = data_q.pop_front();
        end else begin
            host_rsp_valid = 1'b0;
        end
        // Ready about three cycles in four
        host_req_ready = ($urandom() % 4) != 0;
        if (host_req_valid && host_req_ready) begin
            assert (host_req.addr == next_addr) else begin
                $display("[ERROR] t=%0t host_req.addr expected 0x%04h got 0x%04h",
                         $time, next_addr, host_req.addr);
                err_count++;
            end
            next_addr = next_addr + 1'b1;
            req_count++;
            // Never earlier than the previous answer, so order holds
            due = cyc + 1 + int'($urandom() % 6);
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            due_q.push_back(due);
            data_q.push_back(mem[host_req.addr]);
        end
    end
end

endmodule : host_mem_model

`default_nettype wire

/* bench/afu_tb.sv */
/*
 * AFU testbench: MMIO register checks, DMA from a random host memory
 * and sum kernel runs checked against a shadow of local memory
 */
`default_nettype none
`include "afu_consts.svh"

module afu_tb
import asp_mem_pkg::*, asp_ctrl_pkg::*;
();

// Whole sequence takes a few thousand cycles
localparam int MAX_CYCLES = 20000;

logic                   clk, rst;
logic                   mmio_req_valid, mmio_req_ready, mmio_rsp_valid;
mmio_req_t              mmio_req;
mmio_rsp_t              mmio_rsp;
logic                   host_req_valid, host_req_ready, host_rsp_valid;
host_req_t              host_req;
host_rsp_t              host_rsp;
int                     errors, host_errors, host_reads, cycle_count;
logic [`ASP_DATA_W-1:0] lmem_shadow [`ASP_LMEM_DEPTH];
logic [`ASP_DATA_W-1:0] rd_val;

afu i_dut (
    .clk, .rst,
    .mmio_req_valid, .mmio_req, .mmio_req_ready, .mmio_rsp_valid, .mmio_rsp,
    .host_req_valid, .host_req, .host_req_ready, .host_rsp_valid, .host_rsp
);

host_mem_model i_host (
    .clk, .rst,
    .host_req_valid, .host_req, .host_req_ready, .host_rsp_valid, .host_rsp,
    .req_count(host_reads), .err_count(host_errors)
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got == exp) else begin
        $display("[ERROR] t=%0t %s expected 0x%08h got 0x%08h", $time, name, exp, got);
        errors++;
    end
endtask

// Holds the request from a falling edge until a rising edge accepts it
task automatic send_request(input mmio_op_e op, input csr_idx_e idx, input logic [31:0] data);
    @(negedge clk);
    mmio_req_valid = 1'b1;
    mmio_req.op    = op;
    mmio_req.idx   = idx;
    mmio_req.wdata = data;
    while (!mmio_req_ready) begin
        @(negedge clk);
    end
    @(negedge clk);
    mmio_req_valid = 1'b0;
endtask

task automatic write_csr(input csr_idx_e idx, input logic [31:0] data);
    send_request(MMIO_WR, idx, data);
endtask

// Response is due exactly one cycle after acceptance
task automatic read_csr(input csr_idx_e idx, output logic [31:0] data);
    send_request(MMIO_RD, idx, '0);
    check_value("mmio_rsp_valid", 32'd1, 32'(mmio_rsp_valid));
    data = mmio_rsp.rdata;
endtask

task automatic write_readback(input csr_idx_e idx, input logic [31:0] value);
    logic [31:0] got;
    write_csr(idx, value);
    read_csr(idx, got);
    check_value(idx.name(), value, got);
endtask

task automatic poll_status(input logic [31:0] mask, input logic [31:0] value);
    logic [31:0] st;
    read_csr(CSR_STATUS, st);
    while ((st & mask) != value) begin
        read_csr(CSR_STATUS, st);
    end
endtask

function automatic logic [31:0] expected_sum(input logic [7:0] base, input int len);
    logic [31:0] sum;
    sum = '0;
    for (int i = 0; i < len; i++) begin
        sum = sum + lmem_shadow[8'(base + i)];
    end
    return sum;
endfunction

task automatic run_dma(input logic [15:0] src, input logic [7:0] dst, input int len,
                       input bit restart);
    int          reads_before;
    logic [31:0] st;
    write_csr(CSR_DMA_SRC, 32'(src));
    write_csr(CSR_DMA_DST, 32'(dst));
    write_csr(CSR_DMA_LEN, 32'(len));
    i_host.expect_reads(src);
    reads_before = host_reads;
    write_csr(CSR_CONTROL, 32'h1);
    if (restart) begin
        read_csr(CSR_STATUS, st);
        check_value("STATUS.dma_busy", 32'd1, 32'(st[0]));
        write_csr(CSR_CONTROL, 32'h1);
    end
    // Done set and busy clear
    poll_status(32'h3, 32'h2);
    check_value("host read count", 32'(len), 32'(host_reads - reads_before));
    for (int i = 0; i < len; i++) begin
        lmem_shadow[8'(dst + i)] = i_host.mem[16'(src + i)];
    end
endtask

task automatic run_kernel(input logic [7:0] base, input int len);
    logic [31:0] res;
    write_csr(CSR_KERN_BASE, 32'(base));
    write_csr(CSR_KERN_LEN, 32'(len));
    write_csr(CSR_CONTROL, 32'h2);
    poll_status(32'hc, 32'h8);
    read_csr(CSR_KERN_RESULT, res);
    check_value("KERN_RESULT", expected_sum(base, len), res);
endtask

initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
        @(posedge clk);
        cycle_count++;
    end
    $display("Timeout: the run was still going after %0d cycles", MAX_CYCLES);
    $display("error count: testbench %0d, host model %0d", errors, host_errors);
    $display("sim failed");
    $finish;
end

initial begin
    rst            = 1'b1;
    mmio_req_valid = 1'b0;
    mmio_req       = '0;
    errors         = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    check_value("host_req_valid", 32'd0, 32'(host_req_valid));
    check_value("mmio_rsp_valid", 32'd0, 32'(mmio_rsp_valid));
    read_csr(CSR_STATUS, rd_val);
    check_value("STATUS", 32'd0, rd_val);
    read_csr(CSR_ID, rd_val);
    check_value("ID", `ASP_AFU_ID, rd_val);

    write_readback(CSR_DMA_SRC, 32'h0000_beef);
    write_readback(CSR_DMA_DST, 32'h0000_005a);
    write_readback(CSR_DMA_LEN, 32'h0000_0123);
    write_readback(CSR_KERN_BASE, 32'h0000_00a5);
    write_readback(CSR_KERN_LEN, 32'h0000_00ff);

    // Two DMAs into overlapping local ranges, then sums across both
    run_dma(16'd100, 8'd0, 64, 1'b0);
    run_dma(16'd5000, 8'd32, 64, 1'b0);
    run_kernel(8'd0, 96);
    run_kernel(8'd16, 64);

    // Second start lands while the DMA is busy
    run_dma(16'h2000, 8'd128, 64, 1'b1);
    run_kernel(8'd128, 64);

    // Full bank from the top of host memory, then a single word
    run_dma(16'hff80, 8'd0, 256, 1'b0);
    run_kernel(8'd0, 256);
    run_dma(16'd777, 8'd200, 1, 1'b0);
    run_kernel(8'd200, 1);

    @(negedge clk);
    $display("error count: testbench %0d, host model %0d", errors, host_errors);
    if (errors == 0 && host_errors == 0) begin
        $display("sim passed");
    end else begin
        $display("sim failed");
    end
    $finish;
end

endmodule : afu_tb

`default_nettype wire

/* afu.f */
+incdir+src
src/asp_mem_pkg.sv
src/asp_ctrl_pkg.sv
src/mmio_csr.sv
src/dma_engine.sv
src/local_mem_bank.sv
src/kernel_accum.sv
src/afu.sv
bench/host_mem_model.sv
bench/afu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the AFU testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module afu_tb -f afu.f -o afu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/afu_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
